// File: alu.sv
/*
  alu
  add, sub, logic ops and set-less-than, with a zero flag
*/
`timescale 1ns/1ps

module alu import cpu_types_pkg::*; (
  input  word_t  port_a_i,
  input  word_t  port_b_i,
  input  aluop_t alu_op_i,
  output word_t  port_out_o,
  output logic   zero_o
);

  always_comb
  begin
    case (alu_op_i)
      ALU_ADD:  port_out_o = port_a_i + port_b_i;
      ALU_SUB:  port_out_o = port_a_i - port_b_i;
      ALU_AND:  port_out_o = port_a_i & port_b_i;
      ALU_OR:   port_out_o = port_a_i | port_b_i;
      ALU_XOR:  port_out_o = port_a_i ^ port_b_i;
      ALU_SLT:  port_out_o = {31'b0, $signed(port_a_i) < $signed(port_b_i)};
      ALU_SLTU: port_out_o = {31'b0, port_a_i < port_b_i};
      default:  port_out_o = '0;
    endcase
  end

  // branches compare through the subtraction
  assign zero_o = (port_out_o == '0);

endmodule

// File: control_unit.sv
/*
  control unit
  combinational decode of the fetch/decode instruction word
*/
`timescale 1ns/1ps

module control_unit import cpu_types_pkg::*; (
  control_unit_if.cu cuif
);
  opcode_t op;
  logic    known;

  assign op = opcode_t'(cuif.instr[6:0]);

  // shared by R and I types, sub only reachable from R type
  function automatic aluop_t arith_op(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000:  arith_op = sub ? ALU_SUB : ALU_ADD;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b110:  arith_op = ALU_OR;
      3'b111:  arith_op = ALU_AND;
      default: arith_op = ALU_ADD;
    endcase
  endfunction

  always_comb
  begin
    cuif.regWr  = 1'b0;
    cuif.dREN   = 1'b0;
    cuif.dWEN   = 1'b0;
    cuif.aluSrc = 1'b0;
    cuif.aluOp  = ALU_ADD;
    cuif.rdSel  = RD_ALU;
    cuif.pcSrc  = PC_SEQ;
    cuif.jump   = 1'b0;
    cuif.halt   = 1'b0;
    known       = 1'b1;
    case (op)
      RTYPE:
      begin
        cuif.regWr = 1'b1;
        cuif.aluOp = arith_op(cuif.instr[14:12], cuif.instr[30]);
      end
      ITYPE:
      begin
        cuif.regWr  = 1'b1;
        cuif.aluSrc = 1'b1;
        cuif.aluOp  = arith_op(cuif.instr[14:12], 1'b0);
      end
      LUI:
      begin
        cuif.regWr = 1'b1;
        cuif.rdSel = RD_UPPER;
      end
      AUIPC:
      begin
        cuif.regWr = 1'b1;
        cuif.rdSel = RD_PCREL;
      end
      LTYPE:
      begin
        cuif.regWr  = 1'b1;
        cuif.dREN   = 1'b1;
        cuif.aluSrc = 1'b1;
        cuif.rdSel  = RD_LOAD;
      end
      STYPE:
      begin
        cuif.dWEN   = 1'b1;
        cuif.aluSrc = 1'b1;
      end
      BTYPE:
      begin
        cuif.aluOp = ALU_SUB;
        cuif.pcSrc = PC_REL;
      end
      JAL:
      begin
        cuif.regWr = 1'b1;
        cuif.rdSel = RD_NPC;
        cuif.pcSrc = PC_REL;
        cuif.jump  = 1'b1;
      end
      JALR:
      begin
        cuif.regWr  = 1'b1;
        cuif.aluSrc = 1'b1;
        cuif.rdSel  = RD_NPC;
        cuif.pcSrc  = PC_REG;
        cuif.jump   = 1'b1;
      end
      HALT:
      begin
        cuif.halt = 1'b1;
      end
      default:
      begin
        known = 1'b0;
      end
    endcase
  end

  // wrong-path words may be anything, everything else must decode
  unknown_opcode: assert property (@(posedge cuif.CLK) disable iff (!cuif.nRST)
    !cuif.flush |-> known)
    else $error("unknown opcode %b in decode", cuif.instr[6:0]);

endmodule

// File: control_unit_if.sv
/*
  decoder interface
  instruction word in, pipeline control signals out
*/
`timescale 1ns/1ps

interface control_unit_if import cpu_types_pkg::*; (input logic CLK, input logic nRST);
  word_t  instr;
  logic   flush;
  logic   regWr, dREN, dWEN, aluSrc, jump, halt;
  aluop_t aluOp;
  rdsel_t rdSel;
  pcsrc_t pcSrc;

  modport dp (output instr, flush,
              input regWr, dREN, dWEN, aluSrc, aluOp, rdSel, pcSrc, jump, halt);
  modport cu (input CLK, nRST, instr, flush,
              output regWr, dREN, dWEN, aluSrc, aluOp, rdSel, pcSrc, jump, halt);
endinterface

// File: cpu_top.f
cpu_types_pkg.sv
datapath_cache_if.sv
control_unit_if.sv
hazard_unit_if.sv
control_unit.sv
alu.sv
register_file.sv
hazard_unit.sv
datapath.sv
cpu_top.sv
tb_cpu_top.sv

// File: cpu_top.sv
/*
  cpu top
  five-stage RV32I core with flat instruction and data memory ports
*/
`timescale 1ns/1ps

module cpu_top import cpu_types_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t imem_data_i,
  input  word_t dmem_load_i,
  output word_t imem_addr_o,
  output word_t dmem_addr_o,
  output word_t dmem_store_o,
  output logic  dmem_ren_o,
  output logic  dmem_wen_o,
  output logic  halt_o
);
  datapath_cache_if dcif ();

  datapath core_dp (.CLK(CLK), .nRST(nRST), .dpif(dcif.dp));

  // memories answer in the same cycle
  assign dcif.imemload = imem_data_i;
  assign dcif.dmemload = dmem_load_i;

  assign imem_addr_o  = dcif.imemaddr;
  assign dmem_addr_o  = dcif.dmemaddr;
  assign dmem_store_o = dcif.dmemstore;
  assign dmem_ren_o   = dcif.dmemREN;
  assign dmem_wen_o   = dcif.dmemWEN;
  assign halt_o       = dcif.halt;

endmodule

// File: cpu_types_pkg.sv
/*
  cpu types
  word and register index types, instruction and control encodings
  and reset constants for the five-stage RV32I pipeline
*/
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // major opcodes, HALT has every opcode bit set
  typedef enum logic [6:0] {
    RTYPE = 7'b0110011,
    ITYPE = 7'b0010011,
    LUI   = 7'b0110111,
    AUIPC = 7'b0010111,
    LTYPE = 7'b0000011,
    STYPE = 7'b0100011,
    BTYPE = 7'b1100011,
    JAL   = 7'b1101111,
    JALR  = 7'b1100111,
    HALT  = 7'b1111111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  typedef enum logic [2:0] {
    BEQ = 3'b000,
    BNE = 3'b001,
    BLT = 3'b100,
    BGE = 3'b101
  } funct3_b_t;

  // writeback source
  typedef enum logic [2:0] {RD_ALU, RD_LOAD, RD_NPC, RD_UPPER, RD_PCREL} rdsel_t;

  typedef enum logic [1:0] {PC_SEQ, PC_REL, PC_REG} pcsrc_t;

  localparam word_t PC_INIT   = 32'h0000_0000;
  // addi x0, x0, 0 fills squashed decode slots
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// File: datapath.sv
/*
  datapath
  pc, the four pipeline latches, immediates, operand forwarding,
  branch resolution in execute and redirect from execute/memory
*/
`timescale 1ns/1ps

module datapath import cpu_types_pkg::*; (
  input logic          CLK,
  input logic          nRST,
  datapath_cache_if.dp dpif
);
  typedef struct packed {
    word_t instr;
    word_t pc;
  } fd_t;

  typedef struct packed {
    word_t  instr;
    word_t  pc;
    word_t  rdat1;
    word_t  rdat2;
    logic   reg_wr;
    logic   mem_rd;
    logic   mem_wr;
    logic   alu_src;
    aluop_t alu_op;
    rdsel_t rd_sel;
    pcsrc_t pc_src;
    logic   jump;
    logic   halt;
  } dx_t;

  typedef struct packed {
    word_t    pc;
    word_t    uimm;
    word_t    alu;
    word_t    store;
    word_t    target;
    regbits_t rd;
    logic     reg_wr;
    logic     mem_rd;
    logic     mem_wr;
    rdsel_t   rd_sel;
    logic     redirect;
    logic     halt;
  } xm_t;

  typedef struct packed {
    word_t    pc;
    word_t    uimm;
    word_t    alu;
    word_t    load;
    regbits_t rd;
    logic     reg_wr;
    rdsel_t   rd_sel;
  } mw_t;

  word_t pc;
  fd_t   fd;
  dx_t   dx, dx_next;
  xm_t   xm, xm_next;
  mw_t   mw;
  word_t rdat1, rdat2;
  word_t imm_i, imm_s, imm_b, imm_j, imm_u;
  word_t xm_fwd, wb_data, fwd_a, fwd_b, alu_b, alu_out;
  logic  alu_zero, less, taken;

  control_unit_if cuif (CLK, nRST);
  hazard_unit_if  huif (CLK, nRST);

  control_unit  cu (.cuif(cuif));
  hazard_unit   hu (.huif(huif));
  register_file rf (
    .CLK(CLK), .nRST(nRST), .wen_i(mw.reg_wr), .wsel_i(mw.rd), .wdat_i(wb_data),
    .rsel1_i(fd.instr[19:15]), .rsel2_i(fd.instr[24:20]), .rdat1_o(rdat1), .rdat2_o(rdat2)
  );
  alu ex_alu (
    .port_a_i(fwd_a), .port_b_i(alu_b), .alu_op_i(dx.alu_op),
    .port_out_o(alu_out), .zero_o(alu_zero)
  );

  // forwarding and writeback pick a latch's value the same way
  function automatic word_t wb_value(input rdsel_t sel, input word_t alu_res,
                                     input word_t load, input word_t pc_v, input word_t uimm);
    case (sel)
      RD_LOAD:  wb_value = load;
      RD_NPC:   wb_value = pc_v + 32'd4;
      RD_UPPER: wb_value = uimm;
      RD_PCREL: wb_value = pc_v + uimm;
      default:  wb_value = alu_res;
    endcase
  endfunction

  assign cuif.instr = fd.instr;
  assign cuif.flush = huif.flush;

  assign huif.fd_rs1      = fd.instr[19:15];
  assign huif.fd_rs2      = fd.instr[24:20];
  assign huif.dx_rs1      = dx.instr[19:15];
  assign huif.dx_rs2      = dx.instr[24:20];
  assign huif.dx_rd       = dx.instr[11:7];
  assign huif.dx_memRead  = dx.mem_rd;
  assign huif.xm_rd       = xm.rd;
  assign huif.xm_regWr    = xm.reg_wr;
  assign huif.mw_rd       = mw.rd;
  assign huif.mw_regWr    = mw.reg_wr;
  assign huif.xm_redirect = xm.redirect;

  assign imm_i = {{20{dx.instr[31]}}, dx.instr[31:20]};
  assign imm_s = {{20{dx.instr[31]}}, dx.instr[31:25], dx.instr[11:7]};
  assign imm_b = {{19{dx.instr[31]}}, dx.instr[31], dx.instr[7], dx.instr[30:25],
                  dx.instr[11:8], 1'b0};
  assign imm_j = {{11{dx.instr[31]}}, dx.instr[31], dx.instr[19:12], dx.instr[20],
                  dx.instr[30:21], 1'b0};
  assign imm_u = {dx.instr[31:12], 12'b0};

  assign xm_fwd  = wb_value(xm.rd_sel, xm.alu, dpif.dmemload, xm.pc, xm.uimm);
  assign wb_data = wb_value(mw.rd_sel, mw.alu, mw.load, mw.pc, mw.uimm);

  always_comb
  begin
    case (huif.forwardA)
      2'd2:    fwd_a = xm_fwd;
      2'd1:    fwd_a = wb_data;
      default: fwd_a = dx.rdat1;
    endcase
    case (huif.forwardB)
      2'd2:    fwd_b = xm_fwd;
      2'd1:    fwd_b = wb_data;
      default: fwd_b = dx.rdat2;
    endcase
  end

  // stores are the only S-type users of the immediate
  assign alu_b = dx.alu_src ? (dx.mem_wr ? imm_s : imm_i) : fwd_b;

  // signed less-than out of the subtraction
  assign less = (fwd_a[31] ^ fwd_b[31]) ? fwd_a[31] : alu_out[31];

  always_comb
  begin
    case (funct3_b_t'(dx.instr[14:12]))
      BEQ:     taken = alu_zero;
      BNE:     taken = !alu_zero;
      BLT:     taken = less;
      BGE:     taken = !less;
      default: taken = 1'b0;
    endcase
  end

  assign dx_next = '{instr: fd.instr, pc: fd.pc, rdat1: rdat1, rdat2: rdat2,
                     reg_wr: cuif.regWr, mem_rd: cuif.dREN, mem_wr: cuif.dWEN,
                     alu_src: cuif.aluSrc, alu_op: cuif.aluOp, rd_sel: cuif.rdSel,
                     pc_src: cuif.pcSrc, jump: cuif.jump, halt: cuif.halt};

  always_comb
  begin
    xm_next.pc       = dx.pc;
    xm_next.uimm     = imm_u;
    xm_next.alu      = alu_out;
    xm_next.store    = fwd_b;
    xm_next.target   = (dx.pc_src == PC_REG) ? (alu_out & ~32'd1)
                                             : dx.pc + (dx.jump ? imm_j : imm_b);
    xm_next.rd       = dx.instr[11:7];
    xm_next.reg_wr   = dx.reg_wr;
    xm_next.mem_rd   = dx.mem_rd;
    xm_next.mem_wr   = dx.mem_wr;
    xm_next.rd_sel   = dx.rd_sel;
    xm_next.redirect = dx.jump || (dx.pc_src == PC_REL && taken);
    xm_next.halt     = dx.halt;
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      pc        <= PC_INIT;
      fd        <= '{instr: NOP_INSTR, pc: PC_INIT};
      dx        <= '0;
      xm        <= '0;
      mw        <= '0;
      dpif.halt <= 1'b0;
    end
    else
    begin
      mw <= '{pc: xm.pc, uimm: xm.uimm, alu: xm.alu, load: dpif.dmemload,
              rd: xm.rd, reg_wr: xm.reg_wr, rd_sel: xm.rd_sel};
      if (xm.halt)
      begin
        dpif.halt <= 1'b1;
      end
      if (huif.flush)
      begin
        // three younger instructions squashed
        pc <= xm.target;
        fd <= '{instr: NOP_INSTR, pc: xm.target};
        dx <= '0;
        xm <= '0;
      end
      else
      begin
        // the load moves on while a bubble enters execute
        xm <= xm_next;
        dx <= huif.freeze ? '0 : dx_next;
        // fetch parks once HALT is decoded
        if (!(huif.freeze || cuif.halt))
        begin
          pc <= pc + 32'd4;
          fd <= '{instr: dpif.imemload, pc: pc};
        end
      end
    end
  end

  assign dpif.imemaddr  = pc;
  assign dpif.dmemaddr  = xm.alu;
  assign dpif.dmemstore = xm.store;
  assign dpif.dmemREN   = xm.mem_rd;
  assign dpif.dmemWEN   = xm.mem_wr;

  dmem_one_access: assert property (@(posedge CLK) disable iff (!nRST)
    !(dpif.dmemREN && dpif.dmemWEN))
    else $error("load and store enables both high");

endmodule

// File: datapath_cache_if.sv
/*
  datapath to memory interface
  instruction fetch, data access and halt between core and top
*/
`timescale 1ns/1ps

interface datapath_cache_if import cpu_types_pkg::*; ();
  word_t imemaddr, imemload;
  word_t dmemaddr, dmemstore, dmemload;
  logic  dmemREN, dmemWEN;
  logic  halt;

  modport dp (
    input  imemload, dmemload,
    output imemaddr, dmemaddr, dmemstore, dmemREN, dmemWEN, halt
  );

  modport top (
    output imemload, dmemload,
    input  imemaddr, dmemaddr, dmemstore, dmemREN, dmemWEN, halt
  );
endinterface

// File: hazard_unit.sv
/*
  hazard unit
  forward selection for execute operands, load-use freeze,
  and flush on a taken branch or jump
*/
`timescale 1ns/1ps

module hazard_unit import cpu_types_pkg::*; (
  hazard_unit_if.hu huif
);

  // youngest matching writer wins, x0 never forwards
  function automatic logic [1:0] fwd_sel(
    input regbits_t rs,
    input regbits_t xm_rd,
    input logic     xm_wr,
    input regbits_t mw_rd,
    input logic     mw_wr
  );
    if (xm_wr && xm_rd != '0 && xm_rd == rs)
    begin
      fwd_sel = 2'd2;
    end
    else if (mw_wr && mw_rd != '0 && mw_rd == rs)
    begin
      fwd_sel = 2'd1;
    end
    else
    begin
      fwd_sel = 2'd0;
    end
  endfunction

  assign huif.forwardA = fwd_sel(huif.dx_rs1, huif.xm_rd, huif.xm_regWr,
                                 huif.mw_rd, huif.mw_regWr);
  assign huif.forwardB = fwd_sel(huif.dx_rs2, huif.xm_rd, huif.xm_regWr,
                                 huif.mw_rd, huif.mw_regWr);

  // load result only exists after the memory stage
  assign huif.freeze = huif.dx_memRead && (huif.dx_rd != '0) &&
                       (huif.dx_rd == huif.fd_rs1 || huif.dx_rd == huif.fd_rs2);
  assign huif.flush  = huif.xm_redirect;

  // stall and redirect together must leave decode squashed, not held
  flush_beats_freeze: assert property (@(posedge huif.CLK) disable iff (!huif.nRST)
    (huif.freeze && huif.flush) |=>
      (huif.fd_rs1 == '0 && huif.fd_rs2 == '0 && !huif.dx_memRead))
    else $error("freeze held decode through a flush");

endmodule

// File: hazard_unit_if.sv
/*
  hazard interface
  latch register indices in, forward selects, freeze and flush out
*/
`timescale 1ns/1ps

interface hazard_unit_if import cpu_types_pkg::*; (input logic CLK, input logic nRST);
  regbits_t   fd_rs1, fd_rs2, dx_rs1, dx_rs2, dx_rd, xm_rd, mw_rd;
  logic       dx_memRead, xm_regWr, mw_regWr, xm_redirect;
  // 2 from execute/memory, 1 from memory/writeback, 0 none
  logic [1:0] forwardA, forwardB;
  logic       freeze, flush;

  modport dp (output fd_rs1, fd_rs2, dx_rs1, dx_rs2, dx_rd, dx_memRead,
                     xm_rd, xm_regWr, mw_rd, mw_regWr, xm_redirect,
              input  forwardA, forwardB, freeze, flush);
  modport hu (input  CLK, nRST, fd_rs1, fd_rs2, dx_rs1, dx_rs2, dx_rd, dx_memRead,
                     xm_rd, xm_regWr, mw_rd, mw_regWr, xm_redirect,
              output forwardA, forwardB, freeze, flush);
endinterface

// File: register_file.sv
/*
  register file
  32 x 32 with x0 hardwired to zero; writes bypass to same-cycle reads
*/
`timescale 1ns/1ps

module register_file import cpu_types_pkg::*; (
  input  logic     CLK,
  input  logic     nRST,
  input  logic     wen_i,
  input  regbits_t wsel_i,
  input  word_t    wdat_i,
  input  regbits_t rsel1_i,
  input  regbits_t rsel2_i,
  output word_t    rdat1_o,
  output word_t    rdat2_o
);
  word_t regs [32];
  logic  wr_live;

  assign wr_live = wen_i && (wsel_i != '0);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      regs <= '{default: '0};
    end
    else if (wr_live)
    begin
      regs[wsel_i] <= wdat_i;
    end
  end

  // writeback and decode share a cycle
  assign rdat1_o = (wr_live && wsel_i == rsel1_i) ? wdat_i : regs[rsel1_i];
  assign rdat2_o = (wr_live && wsel_i == rsel2_i) ? wdat_i : regs[rsel2_i];

  x0_stays_zero: assert property (@(posedge CLK) disable iff (!nRST)
    (wen_i && wsel_i == '0) |=> (regs[0] == '0 && (rsel1_i != '0 || rdat1_o == '0)))
    else $error("x0 no longer reads as zero");

endmodule

// File: run_sim.sh
#!/bin/bash
# build the testbench with verilator, run it, and look for the pass line in the log
verilator --binary --timing --assert --top-module tb_cpu_top -f cpu_top.f \
  --Mdir obj_dir -o sim_cpu_top > build.log 2>&1 &&
./obj_dir/sim_cpu_top > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "Simulation PASSED" sim.log && exit 0 ||
{ echo "testbench reported errors, see sim.log"; exit 1; }

// File: tb_cpu_top.sv
/*
  cpu top testbench
  random RV32I programs run on the core and on an instruction-set model,
  checking store order, final data memory, reset state and halt
*/
`timescale 1ns/1ps

module tb_cpu_top import cpu_types_pkg::*; ();
  localparam int BODY_LEN    = 52;
  localparam int HALT_CYCLES = 2000;

  logic  CLK, nRST;
  word_t imem_data, dmem_load;
  word_t imem_addr, dmem_addr, dmem_store;
  logic  dmem_ren, dmem_wen, halt;

  word_t       imem [64];
  word_t       dmem [128];
  word_t       mmem [128];
  word_t       mreg [32];
  word_t       exp_addr [$];
  word_t       exp_data [$];
  word_t       exp_a, exp_d;
  logic [31:0] lfsr_state;
  int          store_errors, mem_errors, misc_errors;
  int          store_count, cycles;

  cpu_top uut (
    .CLK(CLK), .nRST(nRST), .imem_data_i(imem_data), .dmem_load_i(dmem_load),
    .imem_addr_o(imem_addr), .dmem_addr_o(dmem_addr), .dmem_store_o(dmem_store),
    .dmem_ren_o(dmem_ren), .dmem_wen_o(dmem_wen), .halt_o(halt)
  );

  initial
  begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // 32-bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[30:0], lfsr_state[0]};
    end
    rand_bits = r;
  endfunction

  function automatic word_t fill_word(input int idx);
    word_t a;
    a = word_t'(idx);
    fill_word = (a * 32'h9e37_79b1) ^ 32'h3c6e_f372;
  endfunction

  function automatic word_t isa_alu(input logic [2:0] f3, input logic sub,
                                    input word_t a, input word_t b);
    case (f3)
      3'b000:  isa_alu = sub ? a - b : a + b;
      3'b010:  isa_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  isa_alu = (a < b) ? 32'd1 : 32'd0;
      3'b100:  isa_alu = a ^ b;
      3'b110:  isa_alu = a | b;
      3'b111:  isa_alu = a & b;
      default: isa_alu = 32'd0;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
      3'b000:  branch_taken = (a == b);
      3'b001:  branch_taken = (a != b);
      3'b100:  branch_taken = ($signed(a) < $signed(b));
      3'b101:  branch_taken = ($signed(a) >= $signed(b));
      default: branch_taken = 1'b0;
    endcase
  endfunction

  task automatic gen_program();
    logic [31:0] r;
    logic [3:0]  kind;
    regbits_t    rd, rs1, rs2;
    logic [2:0]  f3;
    logic        sub;
    logic [11:0] imm;
    logic [4:0]  offb;
    int          idx, k, reach;
    for (int i = 0; i < 64; i++)
    begin
      imem[i] = NOP_INSTR;
    end
    idx   = 0;
    reach = 0;
    while (idx < BODY_LEN)
    begin
      r    = rand_bits(4);
      kind = r[3:0];
      r    = rand_bits(9);
      rd   = {2'b00, r[2:0]};
      rs1  = {2'b00, r[5:3]};
      rs2  = {2'b00, r[8:6]};
      r    = rand_bits(12);
      imm  = r[11:0];
      case (kind)
        4'd0, 4'd1, 4'd2:
        begin
          sub = (r[2:0] == 3'd1);
          case (r[2:0])
            3'd2:    f3 = 3'b010;
            3'd3:    f3 = 3'b011;
            3'd4:    f3 = 3'b100;
            3'd5:    f3 = 3'b110;
            3'd6:    f3 = 3'b111;
            default: f3 = 3'b000;
          endcase
          imem[idx] = {1'b0, sub, 5'b0, rs2, rs1, f3, rd, RTYPE};
        end
        4'd3, 4'd4, 4'd5:
        begin
          case (r[5:3])
            3'd2, 3'd3: f3 = 3'b010;
            3'd4:       f3 = 3'b100;
            3'd5:       f3 = 3'b110;
            3'd6:       f3 = 3'b111;
            default:    f3 = 3'b000;
          endcase
          imem[idx] = {imm, rs1, f3, rd, ITYPE};
        end
        4'd6:    imem[idx] = {r[6:0], rs2, rs1, r[2:0], rd, LUI};
        4'd7:    imem[idx] = {r[6:0], rs2, rs1, r[2:0], rd, AUIPC};
        4'd8, 4'd9:
        begin
          imm       = {4'b0000, r[5:0], 2'b00};
          imem[idx] = {imm, 5'd0, 3'b010, rd, LTYPE};
        end
        4'd10, 4'd11:
        begin
          imm       = {4'b0000, r[5:0], 2'b00};
          imem[idx] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], STYPE};
        end
        4'd15:
        begin
          // auipc then jalr back to the instruction after the jalr,
          // only where no earlier branch can land on the jalr
          if (idx + 1 < BODY_LEN && reach <= idx)
          begin
            rs1       = (rs1 == 5'd0) ? 5'd1 : rs1;
            imem[idx] = {20'd0, rs1, AUIPC};
            idx++;
            imem[idx] = {12'd8, rs1, 3'b000, rd, JALR};
          end
          else
          begin
            imem[idx] = {imm, rs1, 3'b000, rd, ITYPE};
          end
        end
        default:
        begin
          // forward only, never past the register dump
          k = int'(r[1:0]) + 1;
          if (idx + k > BODY_LEN)
          begin
            k = BODY_LEN - idx;
          end
          if (idx + k > reach)
          begin
            reach = idx + k;
          end
          offb = {k[2:0], 2'b00};
          f3   = {r[3], 1'b0, r[2]};
          if (kind == 4'd14)
          begin
            imem[idx] = {1'b0, 6'b0, offb[4:1], 1'b0, 8'b0, rd, JAL};
          end
          else
          begin
            imem[idx] = {7'b0, rs2, rs1, f3, offb[4:1], 1'b0, BTYPE};
          end
        end
      endcase
      idx++;
    end
    for (int i = 1; i < 8; i++)
    begin
      imm       = 12'h100 + 12'(i * 4);
      imem[idx] = {imm[11:5], 5'(i), 5'd0, 3'b010, imm[4:0], STYPE};
      idx++;
    end
    imem[idx] = {25'd0, HALT};
  endtask

  task automatic run_model();
    word_t      pc, npc, ins, a, b, res;
    word_t      imm_i, imm_s, imm_b, imm_j, imm_u, addr;
    logic [2:0] f3;
    logic       wr, done;
    int         steps;
    for (int i = 0; i < 32; i++)
    begin
      mreg[i] = '0;
    end
    for (int i = 0; i < 128; i++)
    begin
      mmem[i] = fill_word(i);
    end
    pc    = PC_INIT;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < 1000)
    begin
      ins   = imem[pc[7:2]];
      f3    = ins[14:12];
      a     = mreg[ins[19:15]];
      b     = mreg[ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      imm_u = {ins[31:12], 12'b0};
      npc   = pc + 32'd4;
      res   = '0;
      wr    = 1'b1;
      case (ins[6:0])
        RTYPE: res = isa_alu(f3, ins[30], a, b);
        ITYPE: res = isa_alu(f3, 1'b0, a, imm_i);
        LUI:   res = imm_u;
        AUIPC: res = pc + imm_u;
        LTYPE:
        begin
          addr = a + imm_i;
          res  = mmem[addr[8:2]];
        end
        STYPE:
        begin
          wr   = 1'b0;
          addr = a + imm_s;
          mmem[addr[8:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        BTYPE:
        begin
          wr = 1'b0;
          if (branch_taken(f3, a, b))
          begin
            npc = pc + imm_b;
          end
        end
        JAL:
        begin
          res = pc + 32'd4;
          npc = pc + imm_j;
        end
        JALR:
        begin
          res = pc + 32'd4;
          npc = (a + imm_i) & ~32'd1;
        end
        HALT:
        begin
          wr   = 1'b0;
          done = 1'b1;
        end
        default:
        begin
          wr   = 1'b0;
          done = 1'b1;
          misc_errors++;
          $display("the model found an instruction it cannot decode at pc %h", pc);
        end
      endcase
      if (wr && ins[11:7] != 5'd0)
      begin
        mreg[ins[11:7]] = res;
      end
      pc = npc;
      steps++;
    end
    if (!done)
    begin
      misc_errors++;
      $display("the model did not reach HALT within 1000 instructions");
    end
  endtask

  task automatic drive_inputs();
    imem_data = imem[imem_addr[7:2]];
    dmem_load = dmem[dmem_addr[8:2]];
  endtask

  task automatic check_store(input word_t addr, input word_t data);
    store_count++;
    assert (!halt)
    else
    begin
      misc_errors++;
      $display("a store to %h appeared after halt_o rose", addr);
    end
    assert (exp_addr.size() > 0)
    else
    begin
      store_errors++;
      $display("FAILED at %0t: store %0d to %h has no model store", $time, store_count, addr);
    end
    if (exp_addr.size() > 0)
    begin
      exp_a = exp_addr.pop_front();
      exp_d = exp_data.pop_front();
      assert (addr == exp_a && data == exp_d)
      else
      begin
        store_errors++;
        $display("FAILED at %0t: store %0d wrote %h to %h, expected %h to %h",
                 $time, store_count, data, addr, exp_d, exp_a);
      end
    end
  endtask

  // store seen between edges commits at the rising edge
  task automatic step_cycle();
    logic  wen;
    word_t addr, data;
    wen  = nRST && dmem_wen;
    addr = dmem_addr;
    data = dmem_store;
    if (wen)
    begin
      check_store(addr, data);
    end
    @(posedge CLK);
    if (wen)
    begin
      dmem[addr[8:2]] = data;
    end
    @(negedge CLK);
    drive_inputs();
  endtask

  task automatic check_quiet();
    assert (!dmem_ren && !dmem_wen && !halt)
    else
    begin
      misc_errors++;
      $display("FAILED at %0t: memory enable or halt high around reset", $time);
    end
  endtask

  initial
  begin
    store_errors = 0;
    mem_errors   = 0;
    misc_errors  = 0;
    store_count  = 0;
    lfsr_state   = 32'h55d6701c;
    nRST         = 1'b0;
    imem_data    = '0;
    dmem_load    = '0;
    gen_program();
    run_model();
    for (int i = 0; i < 128; i++)
    begin
      dmem[i] = fill_word(i);
    end
    for (int c = 0; c < 4; c++)
    begin
      step_cycle();
      check_quiet();
    end
    nRST = 1'b1;
    assert (imem_addr == PC_INIT)
    else
    begin
      misc_errors++;
      $display("FAILED at %0t: fetch address %h after reset", $time, imem_addr);
    end
    cycles = 0;
    while (!halt && cycles < HALT_CYCLES)
    begin
      step_cycle();
      cycles++;
      if (cycles == 1)
      begin
        check_quiet();
      end
    end
    if (!halt)
    begin
      misc_errors++;
      $display("timeout: halt_o did not rise within %0d cycles", HALT_CYCLES);
    end
    else
    begin
      for (int c = 0; c < 10; c++)
      begin
        step_cycle();
        assert (halt)
        else
        begin
          misc_errors++;
          $display("FAILED at %0t: halt_o dropped after rising", $time);
        end
      end
      assert (exp_addr.size() == 0)
      else
      begin
        store_errors++;
        $display("FAILED at %0t: %0d model stores never reached the bus",
                 $time, exp_addr.size());
      end
      for (int i = 0; i < 128; i++)
      begin
        assert (dmem[i] == mmem[i])
        else
        begin
          mem_errors++;
          $display("FAILED at %0t: data word %0d is %h, expected %h",
                   $time, i, dmem[i], mmem[i]);
        end
      end
    end
    $display("%0d stores seen, errors: %0d store, %0d memory, %0d other",
             store_count, store_errors, mem_errors, misc_errors);
    if (store_errors + mem_errors + misc_errors == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
